// File: compile.f
logic/ddr3_pkg.sv
logic/ddr3_clock_divider.sv
logic/ddr3_init_sequencer.sv
logic/ddr3_command_scheduler.sv
logic/ddr3_data_path.sv
logic/ddr3_controller.sv
test/dram_model.sv
test/tb_ddr3_controller.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_ddr3_controller -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: test/tb_ddr3_controller.sv
module tb_ddr3_controller;

	localparam int DIV = 4;
	localparam int TRA = 3;
	localparam int TCI = 4;
	localparam int TXPR = 3;
	localparam int TMRD = 2;
	localparam int TMOD = 3;
	localparam int TZQ = 4;
	localparam int TRCD = 2;
	localparam int TRP = 2;
	localparam int TRFC = 3;
	localparam int TCWL = 5;
	localparam int TCL = 5;
	localparam int TREFI = 40;
	localparam int INIT_TICKS = TRA + TCI + TXPR + 3 * TMRD + TMOD + TZQ;
	localparam int PAIR_TICKS = 1 + TRP + TRFC;  // idle decision, precharge and refresh
	localparam int REFRESH_TICKS = ddr3_pkg::REFRESH_CREDIT_MAX * PAIR_TICKS;
	// a request may sit behind one refresh, then runs its longer column path
	localparam int REQ_TICKS = PAIR_TICKS + 1 + TRCD + TCL + ddr3_pkg::BURST_LEN + 2;
	localparam int LIMIT = (INIT_TICKS + REFRESH_TICKS + 40 * REQ_TICKS) * DIV * 2;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_write;
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] req_addr;
	logic [ddr3_pkg::DQ_BITS-1:0] req_wdata;
	logic req_ready;
	logic rsp_valid;
	logic [ddr3_pkg::DQ_BITS-1:0] rsp_data;
	logic ck;
	logic ck_n;
	logic cke;
	logic reset_n;
	logic cs_n;
	logic ras_n;
	logic cas_n;
	logic we_n;
	logic [ddr3_pkg::BANK_BITS-1:0] ba;
	logic [ddr3_pkg::ROW_BITS-1:0] addr;
	logic [ddr3_pkg::DQ_BITS-1:0] dq_out;
	logic [ddr3_pkg::DQ_BITS-1:0] dq_in;
	logic dq_oe;
	logic dqs_out;
	logic dqs_n_out;
	logic dqs_oe;
	logic dqs_in;
	logic dqs_n_in;

	int seed;
	int fail_count;
	int errors_before;
	int tests_run;
	int cycle_count;
	int reset_edges;
	int mrs_count;
	int refresh_pairs;  // PRECHARGE then REFRESH pairs seen before the first accept
	int strobe_lead;  // clk cycles the strobe has been driven ahead of the data
	int strobe_rises;  // DQS rising edges inside the current write burst
	logic zq_seen;
	logic ready_seen;
	logic prev_reset;
	logic prev_valid;
	logic prev_ready;
	logic prev_write;
	logic prev_dq_oe;
	logic prev_dqs;
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] prev_addr;
	logic [ddr3_pkg::DQ_BITS-1:0] prev_wdata;
	ddr3_pkg::cmd_t cmd;
	ddr3_pkg::cmd_t last_cmd;
	logic [ddr3_pkg::BANK_BITS-1:0] act_bank;
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] pool [0:7];
	logic [ddr3_pkg::DQ_BITS-1:0] sb [0:7];  // last word written to each pool address

	ddr3_controller #(
		.DIVIDE_RATIO(DIV), .T_RESET_ACTIVE(TRA), .T_CKE_INACTIVE(TCI), .T_XPR(TXPR),
		.T_MRD(TMRD), .T_MOD(TMOD), .T_ZQINIT(TZQ), .T_RCD(TRCD), .T_RP(TRP),
		.T_RFC(TRFC), .T_CWL(TCWL), .T_CL(TCL), .T_REFI(TREFI)
	) ddr3_controller_i (
		.clk(clk), .reset(reset),
		.i_req_valid(req_valid), .i_req_write(req_write), .i_req_addr(req_addr),
		.i_req_wdata(req_wdata), .o_req_ready(req_ready),
		.o_rsp_valid(rsp_valid), .o_rsp_data(rsp_data),
		.o_ck(ck), .o_ck_n(ck_n), .o_cke(cke), .o_reset_n(reset_n),
		.o_cs_n(cs_n), .o_ras_n(ras_n), .o_cas_n(cas_n), .o_we_n(we_n),
		.o_ba(ba), .o_addr(addr),
		.o_dq(dq_out), .o_dq_oe(dq_oe), .o_dqs(dqs_out), .o_dqs_n(dqs_n_out),
		.o_dqs_oe(dqs_oe), .i_dq(dq_in), .i_dqs(dqs_in), .i_dqs_n(dqs_n_in)
	);

	dram_model #(
		.T_CL(TCL)
	) dram_model_i (
		.clk(clk), .i_ck(ck), .i_cs_n(cs_n), .i_ras_n(ras_n), .i_cas_n(cas_n),
		.i_we_n(we_n), .i_ba(ba), .i_addr(addr), .i_dq(dq_out), .i_dq_oe(dq_oe),
		.o_dq(dq_in), .o_dqs(dqs_in), .o_dqs_n(dqs_n_in)
	);

	always #2 clk = ~clk;

	// mode register order is MR2, MR3, MR1, MR0
	function automatic logic [ddr3_pkg::BANK_BITS-1:0] mode_bank(input int n);
		case (n)
			0: mode_bank = 3'd2;
			1: mode_bank = 3'd3;
			2: mode_bank = 3'd1;
			default: mode_bank = 3'd0;
		endcase
	endfunction

	function automatic logic [ddr3_pkg::ROW_BITS-1:0] mode_value(input int n);
		case (n)
			0: mode_value = ddr3_pkg::MR2_VALUE;
			1: mode_value = ddr3_pkg::MR3_VALUE;
			2: mode_value = ddr3_pkg::MR1_VALUE;
			default: mode_value = ddr3_pkg::MR0_VALUE;
		endcase
	endfunction

	task automatic report_test(input string name);
		tests_run++;
		$display("test %s finished with %0d errors", name, fail_count - errors_before);
		errors_before = fail_count;
	endtask

	// returns one clk after the edge where the request transferred
	task automatic wait_accept();
		do
			@(posedge clk);
		while (!(req_ready && req_valid));
		#1;
		req_valid = 1'b0;
	endtask

	task automatic send_request(input logic write, input int idx,
		input logic [ddr3_pkg::DQ_BITS-1:0] data);
		req_valid = 1'b1;
		req_write = write;
		req_addr = pool[idx];
		req_wdata = data;
		wait_accept();
		if (write)
			sb[idx] = data;
	endtask

	task automatic check_read(input int idx);
		do
			@(posedge clk);
		while (!rsp_valid);
		assert (rsp_data == sb[idx])
		else
		begin
			$display("Fail %0t: read of %h returned %h, expected %h", $time, pool[idx],
				rsp_data, sb[idx]);
			fail_count++;
		end
		#1;
	endtask

	// pins held in reset, then the first cycle after release
	always @(posedge clk)
	begin
		if ((reset && reset_edges >= 1) || (prev_reset && !reset))
			assert (!reset_n && !cke && !req_ready && !rsp_valid && !dq_oe && !dqs_oe && cs_n)
			else
			begin
				$display("Fail %0t: outputs not in their reset state", $time);
				fail_count++;
			end
		if (reset)
			reset_edges++;
		prev_reset <= reset;
	end

	// pin rules that hold on every cycle
	always @(posedge clk)
	begin
		cycle_count++;
		assert (ck_n === ~ck)
		else
		begin
			$display("Fail %0t: ck_n is not the inverse of ck", $time);
			fail_count++;
		end
		assert (!cke || reset_n)
		else
		begin
			$display("Fail %0t: CKE high while RESET# is low", $time);
			fail_count++;
		end
		if (!reset)
			assert (!req_ready || zq_seen)
			else
			begin
				$display("Fail %0t: request accepted before ZQCL", $time);
				fail_count++;
			end
		if (req_ready && !ready_seen)
		begin
			assert (refresh_pairs >= 4)
			else
			begin
				$display("Fail %0t: only %0d refresh pairs before first accept", $time,
					refresh_pairs);
				fail_count++;
			end
			ready_seen = 1'b1;
		end
		if (!reset && prev_valid && !prev_ready)
			assert (req_valid && req_write == prev_write && req_addr == prev_addr
				&& req_wdata == prev_wdata)
			else
			begin
				$display("Fail %0t: request fields changed while waiting for ready", $time);
				fail_count++;
			end
		prev_valid <= req_valid;
		prev_ready <= req_ready;
		prev_write <= req_write;
		prev_addr <= req_addr;
		prev_wdata <= req_wdata;
		if (cycle_count >= LIMIT)
		begin
			$display("timeout after %0d cycles, the tests did not complete", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	// the write strobe opens one tick ahead of the data and toggles through the burst
	always @(posedge clk)
	begin
		if (!reset)
		begin
			assert (!dqs_oe || dqs_n_out === ~dqs_out)
			else
			begin
				$display("Fail %0t: DQS_N is not the inverse of DQS while driven", $time);
				fail_count++;
			end
			assert (!dq_oe || dqs_oe)
			else
			begin
				$display("Fail %0t: DQ driven while DQS is not", $time);
				fail_count++;
			end
			if (dq_oe && !prev_dq_oe)
				assert (strobe_lead == DIV)
				else
				begin
					$display("Fail %0t: strobe led the data by %0d cycles, expected %0d", $time,
						strobe_lead, DIV);
					fail_count++;
				end
			if (dq_oe && dqs_out && !prev_dqs)
				strobe_rises++;
			if (prev_dq_oe && !dq_oe)
			begin
				assert (strobe_rises >= ddr3_pkg::BURST_LEN)
				else
				begin
					$display("Fail %0t: only %0d DQS rises in the write burst", $time,
						strobe_rises);
					fail_count++;
				end
				strobe_rises = 0;
			end
			if (!dqs_oe)
				strobe_lead = 0;
			else if (!dq_oe)
				strobe_lead++;
		end
		prev_dq_oe <= dq_oe;
		prev_dqs <= dqs_out;
	end

	// command decode at the DRAM, where ck rises
	always @(posedge ck)
	begin
		cmd = ddr3_pkg::cmd_t'({cs_n, ras_n, cas_n, we_n});
		if (!cs_n && cmd != ddr3_pkg::CMD_NOP)
		begin
			case (cmd)
				ddr3_pkg::CMD_MRS:
				begin
					assert (mrs_count < 4 && ba == mode_bank(mrs_count)
						&& addr == mode_value(mrs_count))
					else
					begin
						$display("Fail %0t: MRS %0d has bank %0d value %h", $time, mrs_count,
							ba, addr);
						fail_count++;
					end
					mrs_count++;
				end
				ddr3_pkg::CMD_ZQ:
				begin
					assert (mrs_count == 4 && addr[ddr3_pkg::A10_BIT])
					else
					begin
						$display("Fail %0t: ZQCL out of order or without A10", $time);
						fail_count++;
					end
					zq_seen = 1'b1;
				end
				ddr3_pkg::CMD_REF:
				begin
					assert (last_cmd == ddr3_pkg::CMD_PRE)
					else
					begin
						$display("Fail %0t: REFRESH without PRECHARGE before it", $time);
						fail_count++;
					end
					if (!ready_seen)
						refresh_pairs++;
				end
				ddr3_pkg::CMD_ACT: act_bank = ba;
				ddr3_pkg::CMD_WR, ddr3_pkg::CMD_RD:
					assert (last_cmd == ddr3_pkg::CMD_ACT && ba == act_bank
						&& addr[ddr3_pkg::A10_BIT] && addr[ddr3_pkg::A12_BIT])
					else
					begin
						$display("Fail %0t: column command bank %0d addr %h after %s", $time, ba,
							addr, last_cmd.name());
						fail_count++;
					end
				default: ;
			endcase
			last_cmd = cmd;
		end
	end

	initial
	begin
		logic [31:0] r;
		int idx;
		logic wr;
		seed = 32'h52051f9a;
		fail_count = 0;
		errors_before = 0;
		tests_run = 0;
		cycle_count = 0;
		reset_edges = 0;
		mrs_count = 0;
		refresh_pairs = 0;
		strobe_lead = 0;
		strobe_rises = 0;
		zq_seen = 1'b0;
		ready_seen = 1'b0;
		last_cmd = ddr3_pkg::CMD_NOP;
		act_bank = '0;
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			pool[i] = {i[2:0], r[ddr3_pkg::ROW_BITS-1:0]};  // one bank per address
			sb[i] = '0;
		end
		clk = 1'b0;
		reset = 1'b1;
		// the first write is held valid from reset to see urgent refresh win
		req_valid = 1'b1;
		req_write = 1'b1;
		req_addr = pool[0];
		r = $random(seed);
		req_wdata = r[ddr3_pkg::DQ_BITS-1:0];
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		#1;
		report_test("reset_state");
		while (!zq_seen)
			@(posedge clk);
		#1;
		report_test("power_up_order");
		wait_accept();
		sb[0] = req_wdata;
		report_test("refresh_urgency");
		send_request(1'b0, 0, '0);
		check_read(0);
		report_test("write_then_read");
		for (int n = 0; n < 30; n++)
		begin
			r = $random(seed);
			idx = r[2:0];
			wr = r[3];
			r = $random(seed);
			send_request(wr, idx, r[ddr3_pkg::DQ_BITS-1:0]);
			if (!wr)
				check_read(idx);
		end
		report_test("random_traffic");
		$display("tests %0d, errors %0d", tests_run, fail_count);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: test/dram_model.sv
module dram_model #(
	parameter int T_CL = ddr3_pkg::T_CL
) (
	input logic clk,
	input logic i_ck,
	input logic i_cs_n,
	input logic i_ras_n,
	input logic i_cas_n,
	input logic i_we_n,
	input logic [ddr3_pkg::BANK_BITS-1:0] i_ba,
	input logic [ddr3_pkg::ROW_BITS-1:0] i_addr,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_dq,
	input logic i_dq_oe,
	output logic [ddr3_pkg::DQ_BITS-1:0] o_dq,
	output logic o_dqs,
	output logic o_dqs_n
);

	// one open row per bank, written words are keyed by bank and row
	logic [ddr3_pkg::ROW_BITS-1:0] open_row [0:(1 << ddr3_pkg::BANK_BITS)-1];
	logic [ddr3_pkg::DQ_BITS-1:0] mem [logic [ddr3_pkg::USER_ADDR_BITS-1:0]];
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] write_key;
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] read_key;
	ddr3_pkg::cmd_t cmd;
	int read_wait;  // ck rises left until the read burst starts
	int burst_left;  // ck periods of burst still to go
	logic burst_on;

	assign cmd = ddr3_pkg::cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});
	assign o_dqs = burst_on & i_ck;  // strobe follows ck only during a burst
	assign o_dqs_n = ~o_dqs;

	initial
	begin
		read_wait = 0;
		burst_left = 0;
		burst_on = 1'b0;
		o_dq = '0;
		write_key = '0;
		read_key = '0;
	end

	// commands are taken on the rising edge of ck
	always @(posedge i_ck)
	begin
		if (read_wait != 0)
		begin
			read_wait <= read_wait - 1;
			if (read_wait == 1)
			begin
				burst_left <= ddr3_pkg::BURST_LEN;
				burst_on <= 1'b1;
				o_dq <= mem.exists(read_key) ? mem[read_key] : '0;  // unwritten words read as zero
			end
		end
		else if (burst_left != 0)
		begin
			burst_left <= burst_left - 1;
			if (burst_left == 1)
				burst_on <= 1'b0;
		end
		if (!i_cs_n)
		begin
			case (cmd)
				ddr3_pkg::CMD_ACT: open_row[i_ba] <= i_addr;
				ddr3_pkg::CMD_WR: write_key <= {i_ba, open_row[i_ba]};
				ddr3_pkg::CMD_RD:
				begin
					read_key <= {i_ba, open_row[i_ba]};
					read_wait <= T_CL;  // CL counted in ck rises from this one
				end
				default: ;
			endcase
		end
	end

	// the controller holds one word for the whole write burst
	always @(posedge clk)
	begin
		if (i_dq_oe)
			mem[write_key] = i_dq;
	end

endmodule

// File: logic/ddr3_controller.sv
module ddr3_controller #(
	parameter int DIVIDE_RATIO = ddr3_pkg::DIVIDE_RATIO,
	parameter int T_RESET_ACTIVE = ddr3_pkg::T_RESET_ACTIVE,
	parameter int T_CKE_INACTIVE = ddr3_pkg::T_CKE_INACTIVE,
	parameter int T_XPR = ddr3_pkg::T_XPR,
	parameter int T_MRD = ddr3_pkg::T_MRD,
	parameter int T_MOD = ddr3_pkg::T_MOD,
	parameter int T_ZQINIT = ddr3_pkg::T_ZQINIT,
	parameter int T_RCD = ddr3_pkg::T_RCD,
	parameter int T_RP = ddr3_pkg::T_RP,
	parameter int T_RFC = ddr3_pkg::T_RFC,
	parameter int T_CWL = ddr3_pkg::T_CWL,
	parameter int T_CL = ddr3_pkg::T_CL,
	parameter int T_REFI = ddr3_pkg::T_REFI
) (
	input logic clk,
	input logic reset,

	// user request side, one request in flight at a time
	input logic i_req_valid,
	input logic i_req_write,
	input logic [ddr3_pkg::USER_ADDR_BITS-1:0] i_req_addr,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_req_wdata,
	output logic o_req_ready,
	output logic o_rsp_valid,  // read data comes back without back-pressure
	output logic [ddr3_pkg::DQ_BITS-1:0] o_rsp_data,

	// DRAM clock and command pins
	output logic o_ck,
	output logic o_ck_n,
	output logic o_cke,
	output logic o_reset_n,
	output logic o_cs_n,
	output logic o_ras_n,
	output logic o_cas_n,
	output logic o_we_n,
	output logic [ddr3_pkg::BANK_BITS-1:0] o_ba,
	output logic [ddr3_pkg::ROW_BITS-1:0] o_addr,

	// DQ and DQS split into out, enable and in halves at the pad ring
	output logic [ddr3_pkg::DQ_BITS-1:0] o_dq,
	output logic o_dq_oe,
	output logic o_dqs,
	output logic o_dqs_n,
	output logic o_dqs_oe,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_dq,
	input logic i_dqs,
	input logic i_dqs_n
);

	logic phase_tick;  // one pulse per DRAM clock, at the 90 degree point
	logic dqs_phase_hi;
	logic dqs_phase_lo;
	logic write_window;
	logic strobe_window;  // opens a tick ahead of the data for the write preamble
	logic read_window;
	logic [ddr3_pkg::DQ_BITS-1:0] wdata;

	ddr3_clock_divider #(
		.DIVIDE_RATIO(DIVIDE_RATIO)
	) clock_divider_i (
		.clk(clk),
		.reset(reset),
		.o_ck(o_ck),
		.o_ck_n(o_ck_n),
		.o_phase_tick(phase_tick),
		.o_dqs_phase_hi(dqs_phase_hi),
		.o_dqs_phase_lo(dqs_phase_lo)
	);

	ddr3_command_scheduler #(
		.T_RESET_ACTIVE(T_RESET_ACTIVE),
		.T_CKE_INACTIVE(T_CKE_INACTIVE),
		.T_XPR(T_XPR),
		.T_MRD(T_MRD),
		.T_MOD(T_MOD),
		.T_ZQINIT(T_ZQINIT),
		.T_RCD(T_RCD),
		.T_RP(T_RP),
		.T_RFC(T_RFC),
		.T_CWL(T_CWL),
		.T_CL(T_CL),
		.T_REFI(T_REFI)
	) command_scheduler_i (
		.clk(clk),
		.reset(reset),
		.i_phase_tick(phase_tick),
		.i_req_valid(i_req_valid),
		.i_req_write(i_req_write),
		.i_req_addr(i_req_addr),
		.i_req_wdata(i_req_wdata),
		.o_req_ready(o_req_ready),
		.o_cs_n(o_cs_n),
		.o_ras_n(o_ras_n),
		.o_cas_n(o_cas_n),
		.o_we_n(o_we_n),
		.o_ba(o_ba),
		.o_addr(o_addr),
		.o_cke(o_cke),
		.o_reset_n(o_reset_n),
		.o_write_window(write_window),
		.o_strobe_window(strobe_window),
		.o_read_window(read_window),
		.o_wdata(wdata)
	);

	ddr3_data_path #(
		.DIVIDE_RATIO(DIVIDE_RATIO)
	) data_path_i (
		.clk(clk),
		.reset(reset),
		.i_dqs_phase_hi(dqs_phase_hi),
		.i_dqs_phase_lo(dqs_phase_lo),
		.i_write_window(write_window),
		.i_strobe_window(strobe_window),
		.i_read_window(read_window),
		.i_wdata(wdata),
		.i_dq(i_dq),
		.i_dqs(i_dqs),
		.i_dqs_n(i_dqs_n),
		.o_dq(o_dq),
		.o_dq_oe(o_dq_oe),
		.o_dqs(o_dqs),
		.o_dqs_n(o_dqs_n),
		.o_dqs_oe(o_dqs_oe),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp_data(o_rsp_data)
	);

endmodule

// File: logic/ddr3_data_path.sv
module ddr3_data_path #(
	parameter int DIVIDE_RATIO = ddr3_pkg::DIVIDE_RATIO
) (
	input logic clk,
	input logic reset,
	input logic i_dqs_phase_hi,
	input logic i_dqs_phase_lo,
	input logic i_write_window,
	input logic i_strobe_window,
	input logic i_read_window,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_wdata,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_dq,
	input logic i_dqs,
	input logic i_dqs_n,
	output logic [ddr3_pkg::DQ_BITS-1:0] o_dq,
	output logic o_dq_oe,
	output logic o_dqs,
	output logic o_dqs_n,
	output logic o_dqs_oe,
	output logic o_rsp_valid,
	output logic [ddr3_pkg::DQ_BITS-1:0] o_rsp_data
);

	// half a DRAM period in clk cycles is where the incoming word gets sampled
	localparam int CW = $clog2(DIVIDE_RATIO) + 1;
	localparam logic [CW-1:0] HALF = CW'(DIVIDE_RATIO / 2);

	logic strobe_level;  // differential strobe seen as one level
	logic strobe_prev;
	logic window_prev;
	logic [CW-1:0] delay;  // zero means no capture pending

	// write side, strobe idles low with its complement high outside the window
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_dq_oe <= 1'b0;
			o_dqs_oe <= 1'b0;
		end
		else
		begin
			o_dq_oe <= i_write_window;
			o_dqs_oe <= i_strobe_window;  // a tick early so the preamble reaches the part
		end
	end

	always_ff @(posedge clk)
	begin
		o_dq <= i_wdata;
		o_dqs <= i_strobe_window & i_dqs_phase_hi;  // quarter shift centres DQS in the DQ eye
		o_dqs_n <= i_strobe_window ? i_dqs_phase_lo : 1'b1;
	end

	// read side, each strobe edge inside the window restarts the capture delay
	assign strobe_level = i_dqs & ~i_dqs_n;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			strobe_prev <= 1'b0;
			window_prev <= 1'b0;
			delay <= '0;
		end
		else
		begin
			strobe_prev <= strobe_level;
			window_prev <= i_read_window;
			if (i_read_window && (strobe_level != strobe_prev))
				delay <= 1;
			else if (delay == HALF)
				delay <= '0;
			else if (delay != '0)
				delay <= delay + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (delay == HALF)
			o_rsp_data <= i_dq;  // last word sampled wins
	end

	// the burst is over once the read window drops
	assign o_rsp_valid = window_prev & ~i_read_window;

endmodule

// File: logic/ddr3_command_scheduler.sv
module ddr3_command_scheduler #(
	parameter int T_RESET_ACTIVE = ddr3_pkg::T_RESET_ACTIVE,
	parameter int T_CKE_INACTIVE = ddr3_pkg::T_CKE_INACTIVE,
	parameter int T_XPR = ddr3_pkg::T_XPR,
	parameter int T_MRD = ddr3_pkg::T_MRD,
	parameter int T_MOD = ddr3_pkg::T_MOD,
	parameter int T_ZQINIT = ddr3_pkg::T_ZQINIT,
	parameter int T_RCD = ddr3_pkg::T_RCD,
	parameter int T_RP = ddr3_pkg::T_RP,
	parameter int T_RFC = ddr3_pkg::T_RFC,
	parameter int T_CWL = ddr3_pkg::T_CWL,
	parameter int T_CL = ddr3_pkg::T_CL,
	parameter int T_REFI = ddr3_pkg::T_REFI
) (
	input logic clk,
	input logic reset,
	input logic i_phase_tick,
	input logic i_req_valid,
	input logic i_req_write,
	input logic [ddr3_pkg::USER_ADDR_BITS-1:0] i_req_addr,
	input logic [ddr3_pkg::DQ_BITS-1:0] i_req_wdata,
	output logic o_req_ready,
	output logic o_cs_n,
	output logic o_ras_n,
	output logic o_cas_n,
	output logic o_we_n,
	output logic [ddr3_pkg::BANK_BITS-1:0] o_ba,
	output logic [ddr3_pkg::ROW_BITS-1:0] o_addr,
	output logic o_cke,
	output logic o_reset_n,
	output logic o_write_window,
	output logic o_strobe_window,
	output logic o_read_window,
	output logic [ddr3_pkg::DQ_BITS-1:0] o_wdata
);

	localparam ddr3_pkg::timer_t REFI_LAST = ddr3_pkg::timer_t'(T_REFI - 1);

	ddr3_pkg::cmd_t init_cmd;
	ddr3_pkg::cmd_t run_cmd;
	logic [ddr3_pkg::BANK_BITS-1:0] init_ba;
	logic [ddr3_pkg::ROW_BITS-1:0] init_addr;
	logic [ddr3_pkg::ROW_BITS-1:0] run_addr;
	logic init_done;
	ddr3_pkg::sched_state_t state;
	ddr3_pkg::timer_t timer;
	ddr3_pkg::timer_t last_tick;
	ddr3_pkg::timer_t refi_timer;
	ddr3_pkg::credit_t credit;  // refreshes the part is still owed in advance
	logic [ddr3_pkg::USER_ADDR_BITS-1:0] req_addr;
	logic req_write;
	logic urgent;
	logic state_done;
	logic credit_inc;
	logic credit_dec;

	ddr3_init_sequencer #(
		.T_RESET_ACTIVE(T_RESET_ACTIVE),
		.T_CKE_INACTIVE(T_CKE_INACTIVE),
		.T_XPR(T_XPR),
		.T_MRD(T_MRD),
		.T_MOD(T_MOD),
		.T_ZQINIT(T_ZQINIT)
	) init_sequencer_i (
		.clk(clk),
		.reset(reset),
		.i_phase_tick(i_phase_tick),
		.o_cmd(init_cmd),
		.o_ba(init_ba),
		.o_addr(init_addr),
		.o_cke(o_cke),
		.o_reset_n(o_reset_n),
		.o_init_done(init_done)
	);

	assign urgent = (credit <= ddr3_pkg::REFRESH_URGENT_LEVEL);
	assign state_done = (timer == last_tick);
	assign credit_inc = (state == ddr3_pkg::ST_PRECHARGE) && state_done;  // REFRESH goes out now
	assign credit_dec = (refi_timer == REFI_LAST);

	// a request only goes in on the idle tick that turns it into an ACTIVATE
	assign o_req_ready = i_phase_tick && init_done && (state == ddr3_pkg::ST_IDLE)
		&& !urgent && i_req_valid;

	// how long each state lasts, in ticks, minus one
	always_comb
	begin
		case (state)
			ddr3_pkg::ST_ACTIVATE: last_tick = ddr3_pkg::timer_t'(T_RCD - 1);
			ddr3_pkg::ST_WRITE: last_tick = ddr3_pkg::timer_t'(T_CWL - 1);
			ddr3_pkg::ST_READ: last_tick = ddr3_pkg::timer_t'(T_CL - 1);
			ddr3_pkg::ST_WRITE_DATA: last_tick = ddr3_pkg::timer_t'(ddr3_pkg::BURST_LEN);
			ddr3_pkg::ST_READ_DATA: last_tick = ddr3_pkg::timer_t'(ddr3_pkg::BURST_LEN);
			ddr3_pkg::ST_PRECHARGE: last_tick = ddr3_pkg::timer_t'(T_RP - 1);
			ddr3_pkg::ST_REFRESH: last_tick = ddr3_pkg::timer_t'(T_RFC - 1);
			default: last_tick = '0;  // idle decides on every tick
		endcase
	end

	// refresh credit only starts once the part is up
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credit <= '0;
			refi_timer <= '0;
		end
		else if (i_phase_tick && init_done)
		begin
			refi_timer <= credit_dec ? '0 : refi_timer + 1'b1;
			if (credit_inc && !credit_dec && credit != ddr3_pkg::REFRESH_CREDIT_MAX)
				credit <= credit + 1'b1;
			else if (credit_dec && !credit_inc && credit != '0)
				credit <= credit - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ddr3_pkg::ST_IDLE;
			timer <= '0;
			run_cmd <= ddr3_pkg::CMD_DES;
		end
		else if (i_phase_tick && init_done)
		begin
			run_cmd <= ddr3_pkg::CMD_NOP;  // a command lives for one tick only
			timer <= state_done ? '0 : timer + 1'b1;
			case (state)
				ddr3_pkg::ST_IDLE:
				begin
					// urgent refresh first, then the user, then topping up the credit
					if (urgent || (!i_req_valid && credit != ddr3_pkg::REFRESH_CREDIT_MAX))
					begin
						run_cmd <= ddr3_pkg::CMD_PRE;
						state <= ddr3_pkg::ST_PRECHARGE;
					end
					else if (i_req_valid)
					begin
						run_cmd <= ddr3_pkg::CMD_ACT;
						state <= ddr3_pkg::ST_ACTIVATE;
					end
				end
				ddr3_pkg::ST_ACTIVATE:
				begin
					if (state_done)
					begin
						run_cmd <= req_write ? ddr3_pkg::CMD_WR : ddr3_pkg::CMD_RD;
						state <= req_write ? ddr3_pkg::ST_WRITE : ddr3_pkg::ST_READ;
					end
				end
				ddr3_pkg::ST_WRITE:
					if (state_done) state <= ddr3_pkg::ST_WRITE_DATA;
				ddr3_pkg::ST_READ:
					if (state_done) state <= ddr3_pkg::ST_READ_DATA;
				ddr3_pkg::ST_PRECHARGE:
				begin
					if (state_done)
					begin
						run_cmd <= ddr3_pkg::CMD_REF;
						state <= ddr3_pkg::ST_REFRESH;
					end
				end
				default:
					if (state_done) state <= ddr3_pkg::ST_IDLE;  // both data states and refresh
			endcase
		end
	end

	// request fields are captured at the handshake and held for the whole access
	always_ff @(posedge clk)
	begin
		if (o_req_ready)
		begin
			req_addr <= i_req_addr;
			req_write <= i_req_write;
			o_wdata <= i_req_wdata;
		end
	end

	// the row for ACTIVATE, otherwise A10 and A12 forced high for BL8 with auto-precharge
	always_comb
	begin
		run_addr = req_addr[ddr3_pkg::ROW_BITS-1:0];
		if (state != ddr3_pkg::ST_ACTIVATE)
		begin
			run_addr[ddr3_pkg::A10_BIT] = 1'b1;  // also makes the PRECHARGE hit all banks
			run_addr[ddr3_pkg::A12_BIT] = 1'b1;
		end
	end

	// init owns the pins until it is done and then hands them over for good
	assign {o_cs_n, o_ras_n, o_cas_n, o_we_n} = init_done ? run_cmd : init_cmd;
	assign o_ba = init_done ? req_addr[ddr3_pkg::USER_ADDR_BITS-1 -: ddr3_pkg::BANK_BITS] : init_ba;
	assign o_addr = init_done ? run_addr : init_addr;

	assign o_write_window = (state == ddr3_pkg::ST_WRITE_DATA);
	assign o_strobe_window = o_write_window || (state == ddr3_pkg::ST_WRITE && state_done);
	assign o_read_window = (state == ddr3_pkg::ST_READ_DATA);

endmodule

// File: logic/ddr3_init_sequencer.sv
module ddr3_init_sequencer #(
	parameter int T_RESET_ACTIVE = ddr3_pkg::T_RESET_ACTIVE,
	parameter int T_CKE_INACTIVE = ddr3_pkg::T_CKE_INACTIVE,
	parameter int T_XPR = ddr3_pkg::T_XPR,
	parameter int T_MRD = ddr3_pkg::T_MRD,
	parameter int T_MOD = ddr3_pkg::T_MOD,
	parameter int T_ZQINIT = ddr3_pkg::T_ZQINIT
) (
	input logic clk,
	input logic reset,
	input logic i_phase_tick,
	output ddr3_pkg::cmd_t o_cmd,
	output logic [ddr3_pkg::BANK_BITS-1:0] o_ba,
	output logic [ddr3_pkg::ROW_BITS-1:0] o_addr,
	output logic o_cke,
	output logic o_reset_n,
	output logic o_init_done
);

	// the power-up steps in the order the part needs them, the state simply counts up
	typedef enum logic [3:0] {
		INIT_RESET,
		INIT_CKE_LOW,
		INIT_XPR,
		INIT_MR2,
		INIT_MR3,
		INIT_MR1,
		INIT_MR0,
		INIT_ZQ,
		INIT_DONE
	} init_state_t;

	init_state_t state;
	ddr3_pkg::timer_t timer;  // ticks spent in the current step
	ddr3_pkg::timer_t last_tick;
	logic first_tick;

	assign first_tick = (timer == '0);
	assign o_init_done = (state == INIT_DONE);  // sticks until the next reset

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= INIT_RESET;
			timer <= '0;
		end
		else if (i_phase_tick && !o_init_done)
		begin
			if (timer == last_tick)
			begin
				state <= init_state_t'(state + 1'b1);
				timer <= '0;
			end
			else
				timer <= timer + 1'b1;
		end
	end

	// the pins decode straight from state and timer, which only move on a tick
	always_comb
	begin
		o_cmd = ddr3_pkg::CMD_NOP;
		o_ba = '0;
		o_addr = '0;
		o_cke = 1'b1;
		o_reset_n = 1'b1;
		last_tick = '0;
		case (state)
			INIT_RESET:
			begin
				o_cmd = ddr3_pkg::CMD_DES;
				o_cke = 1'b0;
				o_reset_n = 1'b0;  // RESET# held low while the supplies settle
				last_tick = ddr3_pkg::timer_t'(T_RESET_ACTIVE - 1);
			end
			INIT_CKE_LOW:
			begin
				o_cmd = ddr3_pkg::CMD_DES;
				o_cke = 1'b0;  // ck already runs, CKE stays low a while longer
				last_tick = ddr3_pkg::timer_t'(T_CKE_INACTIVE - 1);
			end
			INIT_XPR:
				last_tick = ddr3_pkg::timer_t'(T_XPR - 1);
			// each MRS goes out once, bank and value stay on the bus for the whole gap
			INIT_MR2:
			begin
				o_cmd = first_tick ? ddr3_pkg::CMD_MRS : ddr3_pkg::CMD_NOP;
				o_ba = 3'd2;
				o_addr = ddr3_pkg::MR2_VALUE;
				last_tick = ddr3_pkg::timer_t'(T_MRD - 1);
			end
			INIT_MR3:
			begin
				o_cmd = first_tick ? ddr3_pkg::CMD_MRS : ddr3_pkg::CMD_NOP;
				o_ba = 3'd3;
				o_addr = ddr3_pkg::MR3_VALUE;
				last_tick = ddr3_pkg::timer_t'(T_MRD - 1);
			end
			INIT_MR1:
			begin
				o_cmd = first_tick ? ddr3_pkg::CMD_MRS : ddr3_pkg::CMD_NOP;
				o_ba = 3'd1;
				o_addr = ddr3_pkg::MR1_VALUE;
				last_tick = ddr3_pkg::timer_t'(T_MRD - 1);
			end
			INIT_MR0:
			begin
				o_cmd = first_tick ? ddr3_pkg::CMD_MRS : ddr3_pkg::CMD_NOP;
				o_ba = 3'd0;
				o_addr = ddr3_pkg::MR0_VALUE;
				last_tick = ddr3_pkg::timer_t'(T_MOD - 1);  // tMOD before any non-MRS command
			end
			INIT_ZQ:
			begin
				o_cmd = first_tick ? ddr3_pkg::CMD_ZQ : ddr3_pkg::CMD_NOP;
				o_addr[ddr3_pkg::A10_BIT] = 1'b1;  // A10 high makes it the long calibration
				last_tick = ddr3_pkg::timer_t'(T_ZQINIT - 1);
			end
			default:
				o_cmd = ddr3_pkg::CMD_NOP;
		endcase
	end

endmodule

// File: logic/ddr3_clock_divider.sv
module ddr3_clock_divider #(
	parameter int DIVIDE_RATIO = ddr3_pkg::DIVIDE_RATIO
) (
	input logic clk,
	input logic reset,
	output logic o_ck,
	output logic o_ck_n,
	output logic o_phase_tick,
	output logic o_dqs_phase_hi,
	output logic o_dqs_phase_lo
);

	// ck toggles every half period, so the counter only spans half a DRAM clock
	localparam int HALF = DIVIDE_RATIO / 2;
	localparam int CW = (HALF > 1) ? $clog2(HALF) : 1;
	localparam logic [CW-1:0] HALF_LAST = CW'(HALF - 1);
	localparam logic [CW-1:0] QUARTER = CW'(DIVIDE_RATIO / 4);  // 90 degrees in clk cycles

	logic [CW-1:0] half_count;
	logic [CW-1:0] half_next;
	logic ck_r;
	logic ck_next;
	logic early;  // still inside the first quarter of the current half

	assign half_next = (half_count == HALF_LAST) ? '0 : half_count + 1'b1;
	assign ck_next = (half_count == HALF_LAST) ? ~ck_r : ck_r;
	assign early = (half_next < QUARTER);

	// every output is registered from the next counter value so they all line up with ck
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			half_count <= '0;
			ck_r <= 1'b0;
			o_phase_tick <= 1'b0;
			o_dqs_phase_hi <= 1'b0;
			o_dqs_phase_lo <= 1'b1;
		end
		else
		begin
			half_count <= half_next;
			ck_r <= ck_next;
			o_dqs_phase_hi <= ck_next ^ early;  // ck delayed by a quarter period
			o_dqs_phase_lo <= ~(ck_next ^ early);
			o_phase_tick <= ck_next & (half_next == QUARTER);  // rising point of the shifted clock
		end
	end

	assign o_ck = ck_r;
	assign o_ck_n = ~ck_r;  // the true complement, no extra skew from a second flop

endmodule

// File: logic/ddr3_pkg.sv
package ddr3_pkg;

	// geometry of the 2 Gb x16 part
	localparam int ROW_BITS = 15;
	localparam int BANK_BITS = 3;
	localparam int DQ_BITS = 16;
	localparam int USER_ADDR_BITS = BANK_BITS + ROW_BITS;  // bank sits above the row

	localparam int A10_BIT = 10;  // auto-precharge on column commands, all banks on precharge
	localparam int A12_BIT = 12;  // high asks for the full burst and not a burst chop
	localparam int BURST_LEN = 8;  // data ticks in one BL8 burst

	// host clk cycles per DRAM clock, DLL-off mode runs the part slowly
	localparam int DIVIDE_RATIO = 4;

	// every tick counter in the design has this width
	localparam int TIMER_BITS = 15;
	typedef logic [TIMER_BITS-1:0] timer_t;

	// MR0 selects fixed BL8, the CL field, DLL reset and a write recovery of 5
	localparam logic [ROW_BITS-1:0] MR0_VALUE = 15'h0310;
	localparam logic [ROW_BITS-1:0] MR1_VALUE = 15'h0003;  // DLL off, 34 ohm driver, no AL
	localparam logic [ROW_BITS-1:0] MR2_VALUE = 15'h0000;  // lowest CWL and no dynamic ODT
	localparam logic [ROW_BITS-1:0] MR3_VALUE = 15'h0000;  // MPR stays off

	// the code is cs_n, ras_n, cas_n, we_n from msb to lsb
	typedef enum logic [3:0] {
		CMD_MRS = 4'b0000,
		CMD_REF = 4'b0001,
		CMD_PRE = 4'b0010,
		CMD_ACT = 4'b0011,
		CMD_WR = 4'b0100,
		CMD_RD = 4'b0101,
		CMD_ZQ = 4'b0110,
		CMD_NOP = 4'b0111,
		CMD_DES = 4'b1111  // only cs_n matters for deselect
	} cmd_t;

	// states of the run-time scheduler once init is over
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACTIVATE,
		ST_WRITE,
		ST_WRITE_DATA,
		ST_READ,
		ST_READ_DATA,
		ST_PRECHARGE,
		ST_REFRESH
	} sched_state_t;

	// up to eight refreshes may be pulled in ahead of time
	localparam int REFRESH_CREDIT_MAX = 8;
	localparam int REFRESH_URGENT_LEVEL = 3;  // at or below this refresh beats user traffic
	typedef logic [$clog2(REFRESH_CREDIT_MAX + 1)-1:0] credit_t;

	// default timing in DRAM clock ticks for a 20 ns clk divided by four (80 ns ck)
	localparam int T_RESET_ACTIVE = 2500;  // 200 us with RESET# low
	localparam int T_CKE_INACTIVE = 6250;  // 500 us with CKE low after RESET# rises
	localparam int T_XPR = 5;  // larger of tRFC plus 10 ns and five clocks
	localparam int T_MRD = 4;
	localparam int T_MOD = 12;
	localparam int T_ZQINIT = 512;
	localparam int T_RCD = 1;  // 13.91 ns is well inside one slow tick
	localparam int T_RP = 1;
	localparam int T_RFC = 2;  // 110 ns
	localparam int T_CWL = 6;  // DLL-off mode only supports CWL of 6
	localparam int T_CL = 6;
	localparam int T_REFI = 97;  // 7.8 us average refresh interval

endpackage
